// ==== sources.f ====
hw/core_pkg.sv
hw/setting_reg.sv
hw/time_64bit.sv
hw/simple_timer.sv
hw/irq_controller.sv
hw/control_outputs.sv
hw/readback_mux.sv
hw/core_top.sv
testbench/core_assertions.sv
testbench/core_tb.sv

// ==== Makefile ====
# Verilator build and run for the control and timing core

VERILATOR  ?= verilator
TOP        ?= core_tb
FILELIST   ?= sources.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then exit 1; fi
	@grep -q "Simulation finished: PASS" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== testbench/core_tb.sv ====
/*
 * Testbench for the control and timing core
 * Random settings writes and status inputs, cycle model, compare tasks, verdict
 */
`default_nettype none

module core_tb;

   localparam int PHASE_LEN   = 400;
   localparam int NUM_PHASES  = 5;
   localparam int CYCLE_LIMIT = 2 * PHASE_LEN * NUM_PHASES + 20;

   logic                     dsp_clk;
   logic                     rst_i;
   core_pkg::settings_bus_t  set_i;
   logic                     pps_i;
   logic                     phy_int_n_i;
   logic                     run_tx_i;
   logic                     run_rx_i;
   logic                     clk_status_i;
   logic                     serdes_link_up_i;
   core_pkg::rb_addr_t       rb_addr_i;
   core_pkg::clock_ctrl_t    clock_ctrl_o;
   core_pkg::serdes_ctrl_t   serdes_ctrl_o;
   core_pkg::adc_ctrl_t      adc_ctrl_o;
   logic                     phy_reset_n_o;
   core_pkg::led_t           leds_o;
   logic                     irq_o;
   core_pkg::set_data_t      rb_data_o;

   integer seed = 43;
   int     cycles = 0;
   int     errors = 0;

   // Model state updated once per clock edge
   core_pkg::clock_ctrl_t  m_clk;
   core_pkg::serdes_ctrl_t m_serdes;
   core_pkg::adc_ctrl_t    m_adc;
   logic                   m_phy_rst;
   core_pkg::led_t         m_led_sw;
   core_pkg::led_t         m_led_src;
   core_pkg::irq_vec_t     m_mask;
   core_pkg::irq_vec_t     m_pending;
   core_pkg::irq_vec_t     m_src_dly;
   core_pkg::vita_time_t   m_time;
   core_pkg::vita_time_t   m_pps_time;
   core_pkg::set_data_t    m_hi_staged;
   core_pkg::set_data_t    m_rb;
   logic [2:0]             m_pps_pipe;
   logic                   m_pps_int;
   logic                   m_one_int;
   logic                   m_per_int;
   logic                   m_one_armed;
   longint                 m_one_due;
   longint                 m_per_len;
   longint                 m_per_due;
   longint                 m_edge;

   core_top u_dut (.*);

   bind core_top core_assertions u_assertions (
      .dsp_clk        (dsp_clk),
      .rst_i          (rst_i),
      .irq_i          (irq_o),
      .mask_i         (u_irq.mask),
      .pps_int_i      (pps_int),
      .onetime_int_i  (onetime_int),
      .periodic_int_i (periodic_int),
      .clock_ctrl_i   (clock_ctrl_o),
      .serdes_ctrl_i  (serdes_ctrl_o),
      .adc_ctrl_i     (adc_ctrl_o),
      .phy_reset_n_i  (phy_reset_n_o)
   );

   initial begin
      dsp_clk = 1'b0;
      forever #10 dsp_clk = ~dsp_clk;
   end

   always @(posedge dsp_clk) begin
      cycles <= cycles + 1;
      if (cycles > CYCLE_LIMIT) begin
         $display("Timeout: run did not end within %0d cycles", CYCLE_LIMIT);
         $display("Simulation finished: FAIL");
         $fatal(1);
      end
   end

   task automatic report_mismatch(input string what, input longint got, input longint exp);
      errors = errors + 1;
      $display("[ERROR] %0t: %s got %0h expected %0h", $time, what, got, exp);
      $display("Simulation finished: FAIL");
      $fatal(1);
   endtask

   task automatic check_ctrl(input core_pkg::clock_ctrl_t  clk_got,
                             input core_pkg::clock_ctrl_t  clk_exp,
                             input core_pkg::serdes_ctrl_t ser_got,
                             input core_pkg::serdes_ctrl_t ser_exp,
                             input core_pkg::adc_ctrl_t    adc_got,
                             input core_pkg::adc_ctrl_t    adc_exp,
                             input logic phy_got, input logic phy_exp);
      if (clk_got !== clk_exp) report_mismatch("clock_ctrl", clk_got, clk_exp);
      if (ser_got !== ser_exp) report_mismatch("serdes_ctrl", ser_got, ser_exp);
      if (adc_got !== adc_exp) report_mismatch("adc_ctrl", adc_got, adc_exp);
      if (phy_got !== phy_exp) report_mismatch("phy_reset_n", phy_got, phy_exp);
   endtask

   task automatic check_leds(input core_pkg::led_t got, input core_pkg::led_t exp);
      if (got !== exp) report_mismatch("leds", got, exp);
   endtask

   task automatic check_word(input core_pkg::set_data_t got, input core_pkg::set_data_t exp);
      if (got !== exp) report_mismatch("readback word", got, exp);
   endtask

   task automatic check_irq(input logic got, input logic exp);
      if (got !== exp) report_mismatch("irq line", got, exp);
   endtask

   // Advance the model by one edge from the inputs seen before it
   task automatic step_model();
      core_pkg::irq_vec_t  src;
      core_pkg::irq_vec_t  ack;
      core_pkg::set_addr_t a;
      core_pkg::set_data_t d;
      logic                wr;
      wr  = set_i.stb;
      a   = set_i.addr;
      d   = set_i.data;
      src = {2'b00, serdes_link_up_i, clk_status_i, ~phy_int_n_i, m_pps_int, m_per_int, m_one_int};
      ack = (wr && a == 8'd201) ? d[7:0] : 8'h00;
      m_edge = m_edge + 1;
      case (rb_addr_i)
         4'd0:    m_rb = m_time[63:32];
         4'd1:    m_rb = m_time[31:0];
         4'd2:    m_rb = m_pps_time[63:32];
         4'd3:    m_rb = m_pps_time[31:0];
         4'd4:    m_rb = 32'd4;
         4'd5:    m_rb = {24'd0, m_pending};
         default: m_rb = 32'd0;
      endcase
      m_pending = (m_pending & ~ack) | (src & ~m_src_dly);
      m_src_dly = src;
      // PPS edge seen on the third high sample
      m_pps_int = m_pps_pipe[1] & ~m_pps_pipe[2];
      if (m_pps_int) m_pps_time = m_time;
      m_pps_pipe = {m_pps_pipe[1:0], pps_i};
      if (wr && a == 8'd193) m_time = {m_hi_staged, d};
      else m_time = m_time + 64'd1;
      // Timers scheduled by edge number
      m_one_int = 1'b0;
      m_per_int = 1'b0;
      if (wr && a == 8'd198) begin
         m_one_armed = (d != 0);
         m_one_due   = m_edge + d;
      end else if (m_one_armed && m_edge == m_one_due) begin
         m_one_int   = 1'b1;
         m_one_armed = 1'b0;
      end
      if (wr && a == 8'd199) begin
         m_per_len = d;
         m_per_due = m_edge + d;
      end else if (m_per_len != 0 && m_edge == m_per_due) begin
         m_per_int = 1'b1;
         m_per_due = m_edge + m_per_len;
      end
      if (wr) begin
         case (a)
            8'd0:   m_clk       = d[4:0];
            8'd1:   m_serdes    = d[3:0];
            8'd2:   m_adc       = d[3:0];
            8'd3:   m_led_sw    = d[7:0];
            8'd4:   m_phy_rst   = d[0];
            8'd8:   m_led_src   = d[7:0];
            8'd192: m_hi_staged = d;
            8'd200: m_mask      = d[7:0];
            default: ;
         endcase
      end
   endtask

   function automatic core_pkg::set_addr_t pick_addr(input int phase, input logic [31:0] r);
      case (phase)
         0:       pick_addr = r[3] ? r[31:24] : {5'd0, r[2:0]};
         1:       pick_addr = r[0] ? 8'd3 : 8'd8;
         2:       pick_addr = r[0] ? 8'd193 : 8'd192;
         3:       pick_addr = {4'd0, r[3:0]};
         default: pick_addr = 8'd198 + {6'd0, r[1:0]};
      endcase
   endfunction

   task automatic drive_random(input int phase);
      logic [31:0]         r;
      logic [31:0]         flips;
      core_pkg::set_addr_t a;
      core_pkg::set_data_t d;
      r     = $random(seed);
      flips = $random(seed);
      a     = pick_addr(phase, r);
      d     = $random(seed);
      // Short timer values so they fire within the phase
      if (a == 8'd198) d = d % 48;
      if (a == 8'd199) d = (d % 24) * 2;
      set_i.stb  <= (r[7:5] < 3'd3);
      set_i.addr <= a;
      set_i.data <= d;
      rb_addr_i  <= r[19:16];
      if (flips[3:0] == 4'd0) pps_i <= ~pps_i;
      if (flips[7:4] == 4'd0) phy_int_n_i <= ~phy_int_n_i;
      if (flips[11:8] == 4'd0) clk_status_i <= ~clk_status_i;
      if (flips[15:12] == 4'd0) serdes_link_up_i <= ~serdes_link_up_i;
      if (flips[18:16] == 3'd0) run_tx_i <= ~run_tx_i;
      if (flips[21:19] == 3'd0) run_rx_i <= ~run_rx_i;
   endtask

   task automatic check_all();
      core_pkg::led_t hw;
      hw = {3'b000, run_tx_i, run_rx_i, clk_status_i, serdes_link_up_i, 1'b0};
      check_ctrl(clock_ctrl_o, m_clk, serdes_ctrl_o, m_serdes, adc_ctrl_o, m_adc,
                 phy_reset_n_o, ~m_phy_rst);
      check_leds(leds_o, (hw & m_led_src) | (m_led_sw & ~m_led_src));
      check_irq(irq_o, |(m_pending & m_mask));
      check_word(rb_data_o, m_rb);
   endtask

   initial begin
      rst_i = 1'b1;
      set_i = '0;
      pps_i = 1'b0;
      phy_int_n_i = 1'b1;
      run_tx_i = 1'b0;
      run_rx_i = 1'b0;
      clk_status_i = 1'b0;
      serdes_link_up_i = 1'b0;
      rb_addr_i = '0;
      {m_clk, m_serdes, m_adc, m_phy_rst, m_led_sw} = '0;
      m_led_src = 8'h1E;
      {m_mask, m_pending, m_src_dly, m_hi_staged, m_rb} = '0;
      {m_time, m_pps_time, m_pps_pipe} = '0;
      {m_pps_int, m_one_int, m_per_int, m_one_armed} = '0;
      m_one_due = 0;
      m_per_len = 0;
      m_per_due = 0;
      m_edge    = 0;
      repeat (3) @(posedge dsp_clk);
      rst_i <= 1'b0;
      @(negedge dsp_clk);
      check_all();
      for (int phase = 0; phase < NUM_PHASES; phase++) begin
         repeat (PHASE_LEN) begin
            @(posedge dsp_clk);
            step_model();
            drive_random(phase);
            @(negedge dsp_clk);
            check_all();
         end
      end
      if (errors == 0 && u_dut.u_assertions.fail_count == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== testbench/core_assertions.sv ====
/*
 * Concurrent checks on the core top level, bound into core_top
 */
`default_nettype none

module core_assertions (
   input wire                         dsp_clk,
   input wire                         rst_i,
   input wire                         irq_i,
   input wire core_pkg::irq_vec_t     mask_i,
   input wire                         pps_int_i,
   input wire                         onetime_int_i,
   input wire                         periodic_int_i,
   input wire core_pkg::clock_ctrl_t  clock_ctrl_i,
   input wire core_pkg::serdes_ctrl_t serdes_ctrl_i,
   input wire core_pkg::adc_ctrl_t    adc_ctrl_i,
   input wire                         phy_reset_n_i
);

   // Number of failed assertions
   int unsigned fail_count = 0;

   ////////////////////////////////////////////////////////////
   // Interrupt line needs an enabled source
   a_irq_masked: assert property (@(posedge dsp_clk) disable iff (rst_i)
      (mask_i == '0) |-> !irq_i)
   else begin
      fail_count++;
      $error("irq high with mask zero");
   end

   // Single-cycle event pulses
   a_pps_pulse: assert property (@(posedge dsp_clk) disable iff (rst_i)
      pps_int_i |=> !pps_int_i)
   else begin
      fail_count++;
      $error("pps pulse too long");
   end

   a_onetime_pulse: assert property (@(posedge dsp_clk) disable iff (rst_i)
      onetime_int_i |=> !onetime_int_i)
   else begin
      fail_count++;
      $error("one-shot pulse too long");
   end

   a_periodic_pulse: assert property (@(posedge dsp_clk) disable iff (rst_i)
      periodic_int_i |=> !periodic_int_i)
   else begin
      fail_count++;
      $error("periodic pulse too long");
   end

   // Control lines idle right after reset
   a_ctrl_reset: assert property (@(posedge dsp_clk)
      rst_i |=> (clock_ctrl_i == '0 && serdes_ctrl_i == '0 && adc_ctrl_i == '0
                 && phy_reset_n_i))
   else begin
      fail_count++;
      $error("control outputs not idle after reset");
   end

endmodule

`default_nettype wire

// ==== hw/core_top.sv ====
/*
 * Control and timing core top level
 * Settings bus fans out to time, timers, interrupts, board control and readback
 */
`default_nettype none

module core_top #(
   parameter core_pkg::set_addr_t TIME_BASE  = core_pkg::SR_TIME64,
   parameter core_pkg::set_addr_t TIMER_BASE = core_pkg::SR_SIMTIMER
) (
   input  wire                          dsp_clk,
   input  wire                          rst_i,
   input  wire core_pkg::settings_bus_t set_i,
   input  wire                          pps_i,
   input  wire                          phy_int_n_i,
   input  wire                          run_tx_i,
   input  wire                          run_rx_i,
   input  wire                          clk_status_i,
   input  wire                          serdes_link_up_i,
   input  wire core_pkg::rb_addr_t      rb_addr_i,
   output core_pkg::clock_ctrl_t        clock_ctrl_o,
   output core_pkg::serdes_ctrl_t       serdes_ctrl_o,
   output core_pkg::adc_ctrl_t          adc_ctrl_o,
   output logic                         phy_reset_n_o,
   output core_pkg::led_t               leds_o,
   output logic                         irq_o,
   output core_pkg::set_data_t          rb_data_o
);

   core_pkg::vita_time_t vita_time;
   core_pkg::vita_time_t vita_time_pps;
   core_pkg::irq_vec_t   irq_src;
   core_pkg::irq_vec_t   irq_pending;
   logic                 pps_int;
   logic                 onetime_int;
   logic                 periodic_int;

   ////////////////////////////////////////////////////////////
   // VITA time and timers
   time_64bit #(.BASE(TIME_BASE)) u_time (
      .dsp_clk         (dsp_clk),
      .rst_i           (rst_i),
      .set_i           (set_i),
      .pps_i           (pps_i),
      .vita_time_o     (vita_time),
      .vita_time_pps_o (vita_time_pps),
      .pps_int_o       (pps_int)
   );

   simple_timer #(.BASE(TIMER_BASE)) u_timer (
      .dsp_clk        (dsp_clk),
      .rst_i          (rst_i),
      .set_i          (set_i),
      .onetime_int_o  (onetime_int),
      .periodic_int_o (periodic_int)
   );

   ////////////////////////////////////////////////////////////
   // Interrupts, PHY line is open drain active low
   assign irq_src = {2'b00, serdes_link_up_i, clk_status_i, ~phy_int_n_i,
                     pps_int, periodic_int, onetime_int};

   irq_controller u_irq (
      .dsp_clk   (dsp_clk),
      .rst_i     (rst_i),
      .set_i     (set_i),
      .irq_src_i (irq_src),
      .pending_o (irq_pending),
      .irq_o     (irq_o)
   );

   // Board control lines and LEDs
   control_outputs u_ctrl (
      .dsp_clk          (dsp_clk),
      .rst_i            (rst_i),
      .set_i            (set_i),
      .run_tx_i         (run_tx_i),
      .run_rx_i         (run_rx_i),
      .clk_status_i     (clk_status_i),
      .serdes_link_up_i (serdes_link_up_i),
      .clock_ctrl_o     (clock_ctrl_o),
      .serdes_ctrl_o    (serdes_ctrl_o),
      .adc_ctrl_o       (adc_ctrl_o),
      .phy_reset_n_o    (phy_reset_n_o),
      .leds_o           (leds_o)
   );

   readback_mux u_rb (
      .dsp_clk         (dsp_clk),
      .rst_i           (rst_i),
      .rb_addr_i       (rb_addr_i),
      .vita_time_i     (vita_time),
      .vita_time_pps_i (vita_time_pps),
      .irq_pending_i   (irq_pending),
      .rb_data_o       (rb_data_o)
   );

endmodule

`default_nettype wire

// ==== hw/readback_mux.sv ====
/*
 * Registered 16-way status word select for host readback
 */
`default_nettype none

module readback_mux (
   input  wire                       dsp_clk,
   input  wire                       rst_i,
   input  wire core_pkg::rb_addr_t   rb_addr_i,
   input  wire core_pkg::vita_time_t vita_time_i,
   input  wire core_pkg::vita_time_t vita_time_pps_i,
   input  wire core_pkg::irq_vec_t   irq_pending_i,
   output core_pkg::set_data_t       rb_data_o
);

   core_pkg::set_data_t word_sel;

   // Unused indices read zero
   always_comb begin
      case (rb_addr_i)
         core_pkg::RB_TIME_HI: word_sel = vita_time_i[63:32];
         core_pkg::RB_TIME_LO: word_sel = vita_time_i[31:0];
         core_pkg::RB_PPS_HI:  word_sel = vita_time_pps_i[63:32];
         core_pkg::RB_PPS_LO:  word_sel = vita_time_pps_i[31:0];
         core_pkg::RB_COMPAT:  word_sel = core_pkg::COMPAT_NUM;
         core_pkg::RB_IRQ:     word_sel = {24'd0, irq_pending_i};
         default:              word_sel = '0;
      endcase
   end

   always_ff @(posedge dsp_clk) begin
      if (rst_i) begin
         rb_data_o <= '0;
      end else begin
         rb_data_o <= word_sel;
      end
   end

endmodule

`default_nettype wire

// ==== hw/control_outputs.sv ====
/*
 * Board control setting registers, PHY reset and LED source selection
 */
`default_nettype none

module control_outputs (
   input  wire                          dsp_clk,
   input  wire                          rst_i,
   input  wire core_pkg::settings_bus_t set_i,
   input  wire                          run_tx_i,
   input  wire                          run_rx_i,
   input  wire                          clk_status_i,
   input  wire                          serdes_link_up_i,
   output core_pkg::clock_ctrl_t        clock_ctrl_o,
   output core_pkg::serdes_ctrl_t       serdes_ctrl_o,
   output core_pkg::adc_ctrl_t          adc_ctrl_o,
   output logic                         phy_reset_n_o,
   output core_pkg::led_t               leds_o
);

   logic           phy_reset;
   core_pkg::led_t led_sw;
   core_pkg::led_t led_src;
   core_pkg::led_t led_hw;

   ////////////////////////////////////////////////////////////
   // Control line registers
   setting_reg #(.ADDR(core_pkg::SR_CLOCK_CTRL), .WIDTH($bits(core_pkg::clock_ctrl_t)))
   u_sr_clock (
      .dsp_clk(dsp_clk), .rst_i(rst_i), .set_i(set_i),
      .value_o(clock_ctrl_o), .changed_o()
   );

   setting_reg #(.ADDR(core_pkg::SR_SERDES_CTRL), .WIDTH($bits(core_pkg::serdes_ctrl_t)))
   u_sr_serdes (
      .dsp_clk(dsp_clk), .rst_i(rst_i), .set_i(set_i),
      .value_o(serdes_ctrl_o), .changed_o()
   );

   setting_reg #(.ADDR(core_pkg::SR_ADC_CTRL), .WIDTH($bits(core_pkg::adc_ctrl_t)))
   u_sr_adc (
      .dsp_clk(dsp_clk), .rst_i(rst_i), .set_i(set_i),
      .value_o(adc_ctrl_o), .changed_o()
   );

   setting_reg #(.ADDR(core_pkg::SR_PHY), .WIDTH(1))
   u_sr_phy (
      .dsp_clk(dsp_clk), .rst_i(rst_i), .set_i(set_i),
      .value_o(phy_reset), .changed_o()
   );

   // Register holds reset active high, pin is active low
   assign phy_reset_n_o = ~phy_reset;

   ////////////////////////////////////////////////////////////
   // LEDs, select bit 1 = hardware, 0 = software
   setting_reg #(.ADDR(core_pkg::SR_LED_SW), .WIDTH($bits(core_pkg::led_t)))
   u_sr_led_sw (
      .dsp_clk(dsp_clk), .rst_i(rst_i), .set_i(set_i),
      .value_o(led_sw), .changed_o()
   );

   setting_reg #(
      .ADDR(core_pkg::SR_LED_SRC), .WIDTH($bits(core_pkg::led_t)),
      .AT_RESET(core_pkg::LED_SRC_RESET)
   ) u_sr_led_src (
      .dsp_clk(dsp_clk), .rst_i(rst_i), .set_i(set_i),
      .value_o(led_src), .changed_o()
   );

   assign led_hw = {3'b000, run_tx_i, run_rx_i, clk_status_i, serdes_link_up_i, 1'b0};
   assign leds_o = (led_src & led_hw) | (~led_src & led_sw);

endmodule

`default_nettype wire

// ==== hw/irq_controller.sv ====
/*
 * Edge-triggered interrupt controller with pending, mask and acknowledge
 */
`default_nettype none

module irq_controller (
   input  wire                          dsp_clk,
   input  wire                          rst_i,
   input  wire core_pkg::settings_bus_t set_i,
   input  wire core_pkg::irq_vec_t      irq_src_i,
   output core_pkg::irq_vec_t           pending_o,
   output logic                         irq_o
);

   core_pkg::irq_vec_t mask;
   core_pkg::irq_vec_t src_dly;
   core_pkg::irq_vec_t src_rise;
   core_pkg::irq_vec_t ack_bits;
   logic               ack_wr;

   setting_reg #(
      .ADDR     (core_pkg::SR_IRQ_MASK),
      .WIDTH    ($bits(core_pkg::irq_vec_t)),
      .AT_RESET (8'h00)
   ) u_sr_mask (
      .dsp_clk   (dsp_clk),
      .rst_i     (rst_i),
      .set_i     (set_i),
      .value_o   (mask),
      .changed_o ()
   );

   assign ack_wr   = set_i.stb && (set_i.addr == core_pkg::SR_IRQ_ACK);
   assign ack_bits = ack_wr ? set_i.data[7:0] : 8'h00;
   assign src_rise = irq_src_i & ~src_dly;

   ////////////////////////////////////////////////////////////
   // Pending bits, a new edge wins over the ack
   always_ff @(posedge dsp_clk) begin
      if (rst_i) begin
         src_dly   <= '0;
         pending_o <= '0;
      end else begin
         src_dly   <= irq_src_i;
         pending_o <= (pending_o & ~ack_bits) | src_rise;
      end
   end

   // Straight from registers, no extra delay
   assign irq_o = |(pending_o & mask);

endmodule

`default_nettype wire

// ==== hw/simple_timer.sv ====
/*
 * One-shot countdown and periodic interrupt generator
 */
`default_nettype none

module simple_timer #(
   parameter core_pkg::set_addr_t BASE = core_pkg::SR_SIMTIMER
) (
   input  wire                          dsp_clk,
   input  wire                          rst_i,
   input  wire core_pkg::settings_bus_t set_i,
   output logic                         onetime_int_o,
   output logic                         periodic_int_o
);

   localparam core_pkg::set_addr_t ADDR_ONESHOT = BASE;
   localparam core_pkg::set_addr_t ADDR_PERIOD  = BASE + 8'd1;

   core_pkg::timer_state_t state;
   core_pkg::set_data_t    onetime_cnt;
   core_pkg::set_data_t    period;
   core_pkg::set_data_t    period_cnt;
   logic                   wr_oneshot;
   logic                   wr_period;

   assign wr_oneshot = set_i.stb && (set_i.addr == ADDR_ONESHOT);
   assign wr_period  = set_i.stb && (set_i.addr == ADDR_PERIOD);

   // One-shot, a zero count cancels
   always_ff @(posedge dsp_clk) begin
      if (rst_i) begin
         state         <= core_pkg::TMR_IDLE;
         onetime_cnt   <= '0;
         onetime_int_o <= 1'b0;
      end else begin
         onetime_int_o <= 1'b0;
         if (wr_oneshot) begin
            onetime_cnt <= set_i.data;
            state       <= (set_i.data != '0) ? core_pkg::TMR_COUNT : core_pkg::TMR_IDLE;
         end else if (state == core_pkg::TMR_COUNT) begin
            if (onetime_cnt == 32'd1) begin
               onetime_int_o <= 1'b1;
               state         <= core_pkg::TMR_IDLE;
            end else begin
               onetime_cnt <= onetime_cnt - 32'd1;
            end
         end
      end
   end

   // Periodic, reloads from the period register
   always_ff @(posedge dsp_clk) begin
      if (rst_i) begin
         period         <= '0;
         period_cnt     <= '0;
         periodic_int_o <= 1'b0;
      end else begin
         periodic_int_o <= 1'b0;
         if (wr_period) begin
            period     <= set_i.data;
            period_cnt <= set_i.data;
         end else if (period != '0) begin
            if (period_cnt == 32'd1) begin
               periodic_int_o <= 1'b1;
               period_cnt     <= period;
            end else begin
               period_cnt <= period_cnt - 32'd1;
            end
         end
      end
   end

endmodule

`default_nettype wire

// ==== hw/time_64bit.sv ====
/*
 * Free-running 64-bit VITA time with staged two-word load
 * and PPS synchronizer, edge detect and time latch
 */
`default_nettype none

module time_64bit #(
   parameter core_pkg::set_addr_t BASE = core_pkg::SR_TIME64
) (
   input  wire                          dsp_clk,
   input  wire                          rst_i,
   input  wire core_pkg::settings_bus_t set_i,
   input  wire                          pps_i,
   output core_pkg::vita_time_t         vita_time_o,
   output core_pkg::vita_time_t         vita_time_pps_o,
   output logic                         pps_int_o
);

   localparam core_pkg::set_addr_t ADDR_HI = BASE;
   localparam core_pkg::set_addr_t ADDR_LO = BASE + 8'd1;

   core_pkg::set_data_t time_hi_staged;
   logic                wr_hi;
   logic                wr_lo;
   logic                pps_meta;
   logic                pps_sync;
   logic                pps_dly;
   logic                pps_rise;

   assign wr_hi    = set_i.stb && (set_i.addr == ADDR_HI);
   assign wr_lo    = set_i.stb && (set_i.addr == ADDR_LO);
   assign pps_rise = pps_sync & ~pps_dly;

   ////////////////////////////////////////////////////////////
   // Time counter, lo word write commits the load
   always_ff @(posedge dsp_clk) begin
      if (rst_i) begin
         time_hi_staged <= '0;
         vita_time_o    <= '0;
      end else begin
         if (wr_hi) begin
            time_hi_staged <= set_i.data;
         end
         if (wr_lo) begin
            vita_time_o <= {time_hi_staged, set_i.data};
         end else begin
            vita_time_o <= vita_time_o + 64'd1;
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // PPS input, two flops then rising edge
   always_ff @(posedge dsp_clk) begin
      if (rst_i) begin
         pps_meta        <= 1'b0;
         pps_sync        <= 1'b0;
         pps_dly         <= 1'b0;
         pps_int_o       <= 1'b0;
         vita_time_pps_o <= '0;
      end else begin
         pps_meta  <= pps_i;
         pps_sync  <= pps_meta;
         pps_dly   <= pps_sync;
         pps_int_o <= pps_rise;
         if (pps_rise) begin
            vita_time_pps_o <= vita_time_o;
         end
      end
   end

endmodule

`default_nettype wire

// ==== hw/setting_reg.sv ====
/*
 * Single addressed setting register with reset value and change pulse
 */
`default_nettype none

module setting_reg #(
   parameter core_pkg::set_addr_t ADDR     = 8'd0,
   parameter int                  WIDTH    = 32,
   parameter logic [WIDTH-1:0]    AT_RESET = '0
) (
   input  wire                         dsp_clk,
   input  wire                         rst_i,
   input  wire core_pkg::settings_bus_t set_i,
   output logic [WIDTH-1:0]            value_o,
   output logic                        changed_o
);

   logic hit;

   // Strobe carrying our address
   assign hit = set_i.stb && (set_i.addr == ADDR);

   always_ff @(posedge dsp_clk) begin
      if (rst_i) begin
         value_o   <= AT_RESET;
         changed_o <= 1'b0;
      end else begin
         changed_o <= hit;
         if (hit) begin
            value_o <= set_i.data[WIDTH-1:0];
         end
      end
   end

endmodule

`default_nettype wire

// ==== hw/core_pkg.sv ====
/*
 * Shared setting addresses, readback indices, widths, control structs
 * and the settings bus struct for the control and timing core
 */
`default_nettype none

package core_pkg;

   ////////////////////////////////////////////////////////////
   // Widths that carry a meaning
   typedef logic [7:0]  set_addr_t;
   typedef logic [31:0] set_data_t;
   typedef logic [63:0] vita_time_t;
   typedef logic [7:0]  irq_vec_t;
   typedef logic [3:0]  rb_addr_t;
   typedef logic [7:0]  led_t;

   // One write per cycle, no handshake
   typedef struct packed {
      logic      stb;
      set_addr_t addr;
      set_data_t data;
   } settings_bus_t;

   ////////////////////////////////////////////////////////////
   // Board control lines
   typedef struct packed {
      logic       clock_ready;
      logic [1:0] clk_en;
      logic [1:0] clk_sel;
   } clock_ctrl_t;

   typedef struct packed {
      logic enable;
      logic prbsen;
      logic loopen;
      logic rx_en;
   } serdes_ctrl_t;

   typedef struct packed {
      logic oe_a;
      logic on_a;
      logic oe_b;
      logic on_b;
   } adc_ctrl_t;

   typedef enum logic {TMR_IDLE, TMR_COUNT} timer_state_t;

   ////////////////////////////////////////////////////////////
   // Setting register map
   localparam set_addr_t SR_CLOCK_CTRL  = 8'd0;
   localparam set_addr_t SR_SERDES_CTRL = 8'd1;
   localparam set_addr_t SR_ADC_CTRL    = 8'd2;
   localparam set_addr_t SR_LED_SW      = 8'd3;
   localparam set_addr_t SR_PHY         = 8'd4;
   localparam set_addr_t SR_LED_SRC     = 8'd8;
   localparam set_addr_t SR_TIME64      = 8'd192;  // Hi word at +0, lo word at +1
   localparam set_addr_t SR_SIMTIMER    = 8'd198;  // One-shot at +0, period at +1
   localparam set_addr_t SR_IRQ_MASK    = 8'd200;
   localparam set_addr_t SR_IRQ_ACK     = 8'd201;

   // HW drives LEDs 4..1 after reset
   localparam led_t      LED_SRC_RESET  = 8'h1E;
   // Bump when the register map changes
   localparam set_data_t COMPAT_NUM     = 32'd4;

   // Readback word indices
   localparam rb_addr_t RB_TIME_HI = 4'd0;
   localparam rb_addr_t RB_TIME_LO = 4'd1;
   localparam rb_addr_t RB_PPS_HI  = 4'd2;
   localparam rb_addr_t RB_PPS_LO  = 4'd3;
   localparam rb_addr_t RB_COMPAT  = 4'd4;
   localparam rb_addr_t RB_IRQ     = 4'd5;

endpackage

`default_nettype wire
